/* build.f */
hdl/wg_net_pkg.sv
hdl/wg_stream_pkg.sv
hdl/wg_header_gen.sv
hdl/wg_payload_path.sv
hdl/wg_verify_fifo.sv
hdl/wg_frame_merge.sv
hdl/wg_transport_framer.sv
sim/tb_wg_framer.sv

/* hdl/wg_frame_merge.sv */
// Header and payload ordering into the beat buffer, verification gate on release
`default_nettype none

module wg_frame_merge #(
   parameter int FIFO_DEPTH = 64
) (
   input  wire logic                 inp,
   input  wire logic                 rst,
   input  wire wg_stream_pkg::beat_s hdr_beat,
   input  wire logic                 hdr_valid,
   output logic                      hdr_ready,
   input  wire wg_stream_pkg::beat_s pay_beat,
   input  wire logic                 pay_valid,
   output logic                      pay_ready,
   input  wire logic                 pay_verified,
   output logic                      hdr_done,
   output wg_stream_pkg::beat_s      out_beat,
   output logic                      out_valid,
   input  wire logic                 out_ready
);
   import wg_stream_pkg::*;

   localparam int HDR_IDX_W = $clog2(HDR_BEATS);

   logic [HDR_IDX_W-1:0] hdr_idx;
   logic                 hdr_fire;
   logic                 pay_fire;
   logic                 out_fire;
   logic                 wr_open;
   logic                 auth_q;     // buffered packet may be released
   logic                 clear_q;    // drop of an unverified packet
   beat_s                wr_beat;
   logic                 wr_en;
   logic                 full;
   logic                 empty;

   // Buffer holds one packet at a time and writes pause
   // while a released packet drains or a drop is pending
   assign wr_open   = !full && !auth_q && !clear_q;
   assign hdr_ready = wr_open;
   assign pay_ready = wr_open && !hdr_valid;

   assign hdr_fire = hdr_valid && hdr_ready;
   assign pay_fire = pay_valid && pay_ready;
   assign wr_en    = hdr_fire || pay_fire;
   assign wr_beat  = hdr_fire ? hdr_beat : pay_beat;

   assign out_valid = !empty && auth_q;
   assign out_fire  = out_valid && out_ready;

   // ===================================================================
   // Header count and verification gate
   // ===================================================================
   always_ff @(posedge inp) begin
      if (rst) begin
         hdr_idx  <= '0;
         hdr_done <= 1'b0;
         auth_q   <= 1'b0;
         clear_q  <= 1'b0;
      end else begin
         hdr_done <= 1'b0;
         clear_q  <= 1'b0;
         if (hdr_fire) begin
            hdr_idx  <= hdr_idx + HDR_IDX_W'(1);
            hdr_done <= (hdr_idx == HDR_IDX_W'(HDR_BEATS - 1));
         end
         if (pay_fire && pay_beat.last) begin
            if (pay_beat.bypass || pay_verified) begin
               auth_q <= 1'b1;
            end else begin
               clear_q <= 1'b1;
            end
         end else if (out_fire && out_beat.last) begin
            auth_q <= 1'b0;
         end
      end
   end

   wg_verify_fifo #(
      .DEPTH(FIFO_DEPTH)
   ) u_fifo (
      .inp     (inp),
      .rst     (rst),
      .clear   (clear_q),
      .wr_beat (wr_beat),
      .wr_en   (wr_en),
      .full    (full),
      .rd_beat (out_beat),
      .rd_en   (out_fire),
      .empty   (empty)
   );

   // Payload beats never slip in between two header beats
   assert property (@(posedge inp) disable iff (rst) pay_fire |-> hdr_idx == '0);

endmodule

`default_nettype wire

/* hdl/wg_header_gen.sv */
// Peer record latch and the four outer Ethernet/IPv4/UDP/WireGuard header beats
`default_nettype none

module wg_header_gen (
   input  wire logic                  inp,
   input  wire logic                  rst,
   input  wire logic                  rec_load,
   input  wire wg_net_pkg::peer_rec_s peer_rec,
   input  wire wg_net_pkg::len_t      inner_len,
   output wg_stream_pkg::beat_s       hdr_beat,
   output logic                       hdr_valid,
   input  wire logic                  hdr_ready,
   output wg_net_pkg::key_t           cipher_key,
   output wg_net_pkg::counter_t       cipher_nonce
);
   import wg_net_pkg::*;
   import wg_stream_pkg::*;

   typedef enum logic [2:0] {
      H_IDLE,
      H_ETH,
      H_IP,
      H_UDP,
      H_WG
   } hdr_state_t;

   hdr_state_t state;
   peer_rec_s  rec_q;
   len_t       pad_len;
   len_t       ip_len_q;
   len_t       udp_len_q;
   counter_t   cnt_le;
   data_t      hdr_be;    // first wire byte in the top bits
   data_t      hdr_le;

   // Inner length rounded up to whole cipher blocks
   assign pad_len = (inner_len + len_t'(15)) & len_t'(16'hFFF0);

   always_ff @(posedge inp) begin
      if (rec_load) begin
         rec_q     <= peer_rec;
         ip_len_q  <= pad_len + IP_OVERHEAD;
         udp_len_q <= pad_len + UDP_OVERHEAD;
      end
   end

   always_ff @(posedge inp) begin
      if (rst) begin
         state <= H_IDLE;
      end else if (rec_load) begin
         state <= H_ETH;
      end else if (hdr_valid && hdr_ready) begin
         case (state)
            H_ETH:   state <= H_IP;
            H_IP:    state <= H_UDP;
            H_UDP:   state <= H_WG;
            default: state <= H_IDLE;
         endcase
      end
   end

   // ===================================================================
   // Header bytes in wire order
   // ===================================================================
   // Counter goes out little-endian, as does the receiver id
   assign cnt_le = {<<8{rec_q.send_cnt}};

   always_comb begin
      case (state)
         H_ETH: hdr_be = {rec_q.remote_mac, rec_q.local_mac, 16'h0800, 8'h45, 8'h00};
         H_IP: hdr_be = {ip_len_q, 16'h0000, 16'h0000, 8'd64, 8'd17, 16'h0000,
                         rec_q.local_ip, rec_q.remote_ip[31:16]};
         H_UDP: hdr_be = {rec_q.remote_ip[15:0], rec_q.local_port, rec_q.remote_port,
                          udp_len_q, 16'h0000, 32'h0400_0000,
                          rec_q.remote_id[7:0], rec_q.remote_id[15:8]};
         default: hdr_be = {rec_q.remote_id[23:16], rec_q.remote_id[31:24], cnt_le, 48'h0};
      endcase
   end

   // Byte 0 sits in the low lane
   assign hdr_le = {<<8{hdr_be}};

   assign hdr_beat = '{data: hdr_le, keep: '1, last: 1'b0, bypass: 1'b0, peer: '0};
   assign hdr_valid = (state != H_IDLE);

   assign cipher_key   = rec_q.key;
   assign cipher_nonce = rec_q.send_cnt;

   // Lookup of the next packet must wait for the current header
   assert property (@(posedge inp) disable iff (rst) rec_load |-> state == H_IDLE);

endmodule

`default_nettype wire

/* hdl/wg_net_pkg.sv */
// Network field types and the peer table record
`default_nettype none

package wg_net_pkg;

   // ===================================================================
   // Address and protocol fields
   // ===================================================================
   typedef logic [47:0] mac_t;
   typedef logic [31:0] ip4_t;
   typedef logic [15:0] port_t;
   // IP or UDP length in bytes
   typedef logic [15:0] len_t;

   // ===================================================================
   // Peer state
   // ===================================================================
   typedef logic [7:0]   peer_idx_t;
   typedef logic [31:0]  peer_id_t;
   typedef logic [255:0] key_t;
   typedef logic [63:0]  counter_t;

   // One entry of the peer table
   typedef struct packed {
      mac_t     local_mac;
      ip4_t     local_ip;
      port_t    local_port;
      mac_t     remote_mac;
      ip4_t     remote_ip;
      port_t    remote_port;
      peer_id_t remote_id;
      key_t     key;
      counter_t send_cnt;    // next nonce for this peer
   } peer_rec_s;

endpackage

`default_nettype wire

/* hdl/wg_payload_path.sv */
// Input control, bypass detection, cipher feed and return, counter write-back
`default_nettype none

module wg_payload_path (
   input  wire logic                 inp,
   input  wire logic                 rst,
   input  wire wg_stream_pkg::beat_s in_beat,
   input  wire logic                 in_valid,
   output logic                      in_ready,
   output wg_net_pkg::peer_idx_t     peer_idx,
   output logic                      rec_load,
   output wg_net_pkg::len_t          inner_len,
   input  wire logic                 hdr_done,
   input  wire wg_net_pkg::counter_t send_cnt,
   output logic                      cnt_wr,
   output wg_net_pkg::counter_t      cnt_value,
   output wg_stream_pkg::beat_s      cipher_in_beat,
   output logic                      cipher_in_valid,
   input  wire logic                 cipher_in_ready,
   input  wire wg_stream_pkg::beat_s cipher_out_beat,
   input  wire logic                 cipher_out_valid,
   output logic                      cipher_out_ready,
   input  wire logic                 cipher_verified,
   output wg_stream_pkg::beat_s      pay_beat,
   output logic                      pay_valid,
   input  wire logic                 pay_ready,
   output logic                      pay_verified
);
   import wg_net_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      BYPASS,
      LOOKUP,
      HEADER,
      CIPHER
   } path_state_t;

   path_state_t state;
   logic        in_done;     // last plaintext beat already sent
   logic        in_fire;
   logic        out_fire;

   assign in_fire  = in_valid && in_ready;
   assign out_fire = cipher_out_valid && cipher_out_ready;

   // First beat waits on the input until the header is out,
   // so its inner IPv4 length is still there at rec_load
   assign inner_len      = len_t'({in_beat.data[23:16], in_beat.data[31:24]});
   assign cipher_in_beat = in_beat;

   always_ff @(posedge inp) begin
      if (rst) begin
         state    <= IDLE;
         in_done  <= 1'b0;
         rec_load <= 1'b0;
         cnt_wr   <= 1'b0;
      end else begin
         // Table answers one cycle after the lookup
         rec_load <= (state == LOOKUP);
         cnt_wr   <= 1'b0;
         case (state)
            IDLE: begin
               if (in_valid) begin
                  state <= in_beat.bypass ? BYPASS : LOOKUP;
               end
            end
            BYPASS: begin
               if (in_fire && in_beat.last) begin
                  state <= IDLE;
               end
            end
            LOOKUP: state <= HEADER;
            HEADER: begin
               if (hdr_done) begin
                  state <= CIPHER;
               end
            end
            CIPHER: begin
               if (in_fire && in_beat.last) begin
                  in_done <= 1'b1;
               end
               if (out_fire && cipher_out_beat.last) begin
                  state   <= IDLE;
                  in_done <= 1'b0;
                  cnt_wr  <= 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge inp) begin
      if (state == IDLE && in_valid) begin
         peer_idx <= in_beat.peer;
      end
      if (out_fire && cipher_out_beat.last) begin
         cnt_value <= send_cnt + counter_t'(1);
      end
   end

   // ===================================================================
   // Stream steering
   // ===================================================================
   always_comb begin
      in_ready         = 1'b0;
      pay_valid        = 1'b0;
      pay_beat         = cipher_out_beat;
      pay_verified     = 1'b0;
      cipher_in_valid  = 1'b0;
      cipher_out_ready = 1'b0;
      case (state)
         BYPASS: begin
            in_ready  = pay_ready;
            pay_valid = in_valid;
            pay_beat  = in_beat;
         end
         CIPHER: begin
            cipher_in_valid  = in_valid && !in_done;
            in_ready         = cipher_in_ready && !in_done;
            pay_valid        = cipher_out_valid;
            cipher_out_ready = pay_ready;
            pay_verified     = cipher_verified;
         end
         default: begin
            in_ready = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hdl/wg_stream_pkg.sv */
// Stream beat types, the beat struct and outer header constants
`default_nettype none

package wg_stream_pkg;

   typedef logic [127:0] data_t;
   typedef logic [15:0]  keep_t;

   // One beat of the 128-bit packet stream
   typedef struct packed {
      data_t                 data;
      keep_t                 keep;
      logic                  last;
      logic                  bypass;
      wg_net_pkg::peer_idx_t peer;
   } beat_s;

   // ===================================================================
   // Outer header
   // ===================================================================
   // Ethernet, IPv4, UDP and WireGuard transport header
   localparam int HDR_BEATS = 4;

   // IPv4 20 + UDP 8 + WireGuard 16 + tag 16
   localparam wg_net_pkg::len_t IP_OVERHEAD = 16'd60;
   // UDP 8 + WireGuard 16 + tag 16
   localparam wg_net_pkg::len_t UDP_OVERHEAD = 16'd40;

endpackage

`default_nettype wire

/* hdl/wg_transport_framer.sv */
// WireGuard transport framer top level with header, payload and merge stages
`default_nettype none

module wg_transport_framer #(
   parameter int FIFO_DEPTH = 64
) (
   input  wire logic                  inp,
   input  wire logic                  rst,
   // Plain packet stream
   input  wire wg_stream_pkg::beat_s  in_beat,
   input  wire logic                  in_valid,
   output logic                       in_ready,
   // Peer table
   output wg_net_pkg::peer_idx_t      peer_idx,
   input  wire wg_net_pkg::peer_rec_s peer_rec,
   output logic                       cnt_wr,
   output wg_net_pkg::counter_t       cnt_value,
   // Cipher engine
   output wg_stream_pkg::beat_s       cipher_in_beat,
   output logic                       cipher_in_valid,
   input  wire logic                  cipher_in_ready,
   input  wire wg_stream_pkg::beat_s  cipher_out_beat,
   input  wire logic                  cipher_out_valid,
   output logic                       cipher_out_ready,
   input  wire logic                  cipher_verified,
   output wg_net_pkg::key_t           cipher_key,
   output wg_net_pkg::counter_t       cipher_nonce,
   // Framed packet stream
   output wg_stream_pkg::beat_s       out_beat,
   output logic                       out_valid,
   input  wire logic                  out_ready
);
   import wg_net_pkg::*;
   import wg_stream_pkg::*;

   logic  rec_load;
   len_t  inner_len;
   logic  hdr_done;
   beat_s hdr_beat;
   logic  hdr_valid;
   logic  hdr_ready;
   beat_s pay_beat;
   logic  pay_valid;
   logic  pay_ready;
   logic  pay_verified;

   wg_header_gen u_hdr (
      .inp          (inp),
      .rst          (rst),
      .rec_load     (rec_load),
      .peer_rec     (peer_rec),
      .inner_len    (inner_len),
      .hdr_beat     (hdr_beat),
      .hdr_valid    (hdr_valid),
      .hdr_ready    (hdr_ready),
      .cipher_key   (cipher_key),
      .cipher_nonce (cipher_nonce)
   );

   wg_payload_path u_pay (
      .inp              (inp),
      .rst              (rst),
      .in_beat          (in_beat),
      .in_valid         (in_valid),
      .in_ready         (in_ready),
      .peer_idx         (peer_idx),
      .rec_load         (rec_load),
      .inner_len        (inner_len),
      .hdr_done         (hdr_done),
      .send_cnt         (cipher_nonce),
      .cnt_wr           (cnt_wr),
      .cnt_value        (cnt_value),
      .cipher_in_beat   (cipher_in_beat),
      .cipher_in_valid  (cipher_in_valid),
      .cipher_in_ready  (cipher_in_ready),
      .cipher_out_beat  (cipher_out_beat),
      .cipher_out_valid (cipher_out_valid),
      .cipher_out_ready (cipher_out_ready),
      .cipher_verified  (cipher_verified),
      .pay_beat         (pay_beat),
      .pay_valid        (pay_valid),
      .pay_ready        (pay_ready),
      .pay_verified     (pay_verified)
   );

   wg_frame_merge #(
      .FIFO_DEPTH(FIFO_DEPTH)
   ) u_merge (
      .inp          (inp),
      .rst          (rst),
      .hdr_beat     (hdr_beat),
      .hdr_valid    (hdr_valid),
      .hdr_ready    (hdr_ready),
      .pay_beat     (pay_beat),
      .pay_valid    (pay_valid),
      .pay_ready    (pay_ready),
      .pay_verified (pay_verified),
      .hdr_done     (hdr_done),
      .out_beat     (out_beat),
      .out_valid    (out_valid),
      .out_ready    (out_ready)
   );

endmodule

`default_nettype wire

/* hdl/wg_verify_fifo.sv */
// Beat buffer with synchronous clear for discarding unverified packets
`default_nettype none

module wg_verify_fifo #(
   parameter int DEPTH = 64
) (
   input  wire logic                 inp,
   input  wire logic                 rst,
   input  wire logic                 clear,
   input  wire wg_stream_pkg::beat_s wr_beat,
   input  wire logic                 wr_en,
   output logic                      full,
   output wg_stream_pkg::beat_s      rd_beat,
   input  wire logic                 rd_en,
   output logic                      empty
);
   import wg_stream_pkg::*;

   localparam int ADDR_W = $clog2(DEPTH);

   beat_s           mem [DEPTH];
   // Extra top bit tells full from empty
   logic [ADDR_W:0] wr_ptr;
   logic [ADDR_W:0] rd_ptr;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   // Show-ahead read
   assign rd_beat = mem[rd_ptr[ADDR_W-1:0]];

   always_ff @(posedge inp) begin
      if (wr_en && !full) begin
         mem[wr_ptr[ADDR_W-1:0]] <= wr_beat;
      end
   end

   always_ff @(posedge inp) begin
      if (rst || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en && !full) begin
            wr_ptr <= wr_ptr + (ADDR_W + 1)'(1);
         end
         if (rd_en && !empty) begin
            rd_ptr <= rd_ptr + (ADDR_W + 1)'(1);
         end
      end
   end

   // Upstream handshakes must respect the buffer levels
   assert property (@(posedge inp) disable iff (rst) wr_en |-> !full);
   assert property (@(posedge inp) disable iff (rst) rd_en |-> !empty);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_wg_framer -f build.f

out=$(./obj_dir/Vtb_wg_framer) || true
echo "$out"

# Pass only if the testbench reported a clean finish
echo "$out" | grep -qxF "Finished with no errors"

/* sim/tb_wg_framer.sv */
// Testbench for the transport framer with peer table model, cipher model and directed tests
`default_nettype none

module tb_wg_framer;
   import wg_net_pkg::*;
   import wg_stream_pkg::*;

   localparam int TIMEOUT = 500;
   localparam int PEERS   = 4;

   logic      inp;
   logic      rst;
   beat_s     in_beat;
   logic      in_valid;
   logic      in_ready;
   peer_idx_t peer_idx;
   peer_rec_s peer_rec;
   logic      cnt_wr;
   counter_t  cnt_value;
   beat_s     cipher_in_beat;
   logic      cipher_in_valid;
   logic      cipher_in_ready;
   beat_s     cipher_out_beat;
   logic      cipher_out_valid;
   logic      cipher_out_ready;
   logic      cipher_verified;
   key_t      cipher_key;
   counter_t  cipher_nonce;
   beat_s     out_beat;
   logic      out_valid;
   logic      out_ready;

   peer_rec_s  init_recs [PEERS];
   peer_rec_s  peer_table [PEERS];
   counter_t   exp_cnt [PEERS];     // counter each peer should hold
   logic       cipher_pass;         // tag result reported with the last beat
   logic       stall_out;
   beat_s      sent_q [$];
   beat_s      exp_q [$];
   beat_s      got_q [$];
   logic [7:0] hdr_bytes [64];      // outer header in wire order

   wg_transport_framer uut (
      .inp              (inp),
      .rst              (rst),
      .in_beat          (in_beat),
      .in_valid         (in_valid),
      .in_ready         (in_ready),
      .peer_idx         (peer_idx),
      .peer_rec         (peer_rec),
      .cnt_wr           (cnt_wr),
      .cnt_value        (cnt_value),
      .cipher_in_beat   (cipher_in_beat),
      .cipher_in_valid  (cipher_in_valid),
      .cipher_in_ready  (cipher_in_ready),
      .cipher_out_beat  (cipher_out_beat),
      .cipher_out_valid (cipher_out_valid),
      .cipher_out_ready (cipher_out_ready),
      .cipher_verified  (cipher_verified),
      .cipher_key       (cipher_key),
      .cipher_nonce     (cipher_nonce),
      .out_beat         (out_beat),
      .out_valid        (out_valid),
      .out_ready        (out_ready)
   );

   initial begin : clock_gen
      inp = 1'b0;
      forever #10 inp = ~inp;
   end

   // ===================================================================
   // Peer table and cipher models
   // ===================================================================
   // Record comes back one cycle after the index and is loaded from init_recs in reset
   initial begin : peer_table_model
      peer_rec <= '0;
      forever begin
         @(posedge inp);
         if (rst) begin
            for (int i = 0; i < PEERS; i++) begin
               peer_table[i] <= init_recs[i];
            end
         end else if (cnt_wr) begin
            peer_table[peer_idx[1:0]].send_cnt <= cnt_value;
         end
         peer_rec <= peer_table[peer_idx[1:0]];
      end
   end

   // Single stage that XORs key byte 0 and nonce byte 0 into every lane
   assign cipher_in_ready = !cipher_out_valid || cipher_out_ready;

   initial begin : cipher_model
      beat_s b;
      cipher_out_beat  <= '0;
      cipher_out_valid <= 1'b0;
      cipher_verified  <= 1'b0;
      forever begin
         @(posedge inp);
         if (rst) begin
            cipher_out_valid <= 1'b0;
            cipher_verified  <= 1'b0;
         end else if (cipher_in_valid && cipher_in_ready) begin
            b      = cipher_in_beat;
            b.data = b.data ^ {16{cipher_key[7:0] ^ cipher_nonce[7:0]}};
            cipher_out_beat  <= b;
            cipher_out_valid <= 1'b1;
            cipher_verified  <= cipher_pass && b.last;
         end else if (cipher_out_ready) begin
            cipher_out_valid <= 1'b0;
         end
      end
   end

   // ===================================================================
   // Helpers
   // ===================================================================
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check(input string name, input logic [127:0] got, input logic [127:0] want);
      if (got !== want) begin
         fail_run($sformatf("MISMATCH at time %0t: %s is %h, expected %h",
                            $time, name, got, want));
      end
   endtask

   task automatic check_beat(input int idx, input beat_s got, input beat_s want);
      check($sformatf("out_beat[%0d].data", idx), got.data, want.data);
      check($sformatf("out_beat[%0d].keep", idx), 128'(got.keep), 128'(want.keep));
      check($sformatf("out_beat[%0d].last", idx), 128'(got.last), 128'(want.last));
      check($sformatf("out_beat[%0d].bypass", idx), 128'(got.bypass), 128'(want.bypass));
      check($sformatf("out_beat[%0d].peer", idx), 128'(got.peer), 128'(want.peer));
   endtask

   task automatic next_cycle();
      @(posedge inp);
      #2;
   endtask

   task automatic put_be(input int pos, input int n, input logic [63:0] val);
      for (int i = 0; i < n; i++) begin
         hdr_bytes[pos + i] = val[8 * (n - 1 - i) +: 8];
      end
   endtask

   task automatic put_le(input int pos, input int n, input logic [63:0] val);
      for (int i = 0; i < n; i++) begin
         hdr_bytes[pos + i] = val[8 * i +: 8];
      end
   endtask

   // Random payload with the inner IPv4 length in bytes 2 and 3 of the first beat
   task automatic make_payload(input int n, input int len, input int p, input logic byp);
      beat_s b;
      int    rem;
      sent_q.delete();
      rem = len % 16;
      for (int i = 0; i < n; i++) begin
         b.data   = {$urandom(), $urandom(), $urandom(), $urandom()};
         b.keep   = '1;
         b.last   = (i == n - 1);
         b.bypass = byp;
         b.peer   = peer_idx_t'(p);
         if (i == 0 && !byp) begin
            b.data[23:16] = 8'(len >> 8);
            b.data[31:24] = 8'(len);
         end
         if (i == n - 1 && rem != 0) begin
            b.keep = keep_t'((32'd1 << rem) - 32'd1);
         end
         sent_q.push_back(b);
      end
   endtask

   // Outer header built from the record byte by byte in wire order
   task automatic add_expected_header(input int p, input int len);
      peer_rec_s r;
      len_t      padded;
      beat_s     b;
      r      = init_recs[p];
      padded = len_t'(((len + 15) / 16) * 16);
      foreach (hdr_bytes[i]) begin
         hdr_bytes[i] = 8'h00;
      end
      put_be(0, 6, 64'(r.remote_mac));
      put_be(6, 6, 64'(r.local_mac));
      put_be(12, 2, 64'h0800);
      hdr_bytes[14] = 8'h45;
      put_be(16, 2, 64'(padded + 16'd60));
      hdr_bytes[22] = 8'd64;
      hdr_bytes[23] = 8'd17;
      put_be(26, 4, 64'(r.local_ip));
      put_be(30, 4, 64'(r.remote_ip));
      put_be(34, 2, 64'(r.local_port));
      put_be(36, 2, 64'(r.remote_port));
      put_be(38, 2, 64'(padded + 16'd40));
      // Transport message type, receiver id and counter go out little-endian
      put_le(42, 4, 64'd4);
      put_le(46, 4, 64'(r.remote_id));
      put_le(50, 8, exp_cnt[p]);
      for (int k = 0; k < 4; k++) begin
         b      = '0;
         b.keep = '1;
         for (int j = 0; j < 16; j++) begin
            b.data[8 * j +: 8] = hdr_bytes[16 * k + j];
         end
         exp_q.push_back(b);
      end
   endtask

   task automatic send_packet();
      int waited;
      foreach (sent_q[i]) begin
         in_beat  = sent_q[i];
         in_valid = 1'b1;
         waited   = 0;
         @(negedge inp);
         while (!in_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
               fail_run($sformatf("Timeout: input beat %0d was never accepted", i));
            end
            next_cycle();
            @(negedge inp);
         end
         next_cycle();
      end
      in_valid = 1'b0;
   endtask

   task automatic receive_packet();
      int    waited;
      int    idx;
      beat_s want;
      got_q.delete();
      idx = 0;
      while (exp_q.size() > 0) begin
         want      = exp_q.pop_front();
         waited    = 0;
         out_ready = stall_out ? ($urandom_range(2) != 0) : 1'b1;
         @(negedge inp);
         while (!(out_valid && out_ready)) begin
            waited++;
            if (waited > TIMEOUT) begin
               fail_run($sformatf("Timeout: output beat %0d never appeared", idx));
            end
            next_cycle();
            out_ready = stall_out ? ($urandom_range(2) != 0) : 1'b1;
            @(negedge inp);
         end
         got_q.push_back(out_beat);
         check_beat(idx, out_beat, want);
         idx++;
         next_cycle();
      end
      out_ready = 1'b0;
      // No beat beyond the packet
      @(negedge inp);
      check("out_valid", 128'(out_valid), 128'(0));
      next_cycle();
   endtask

   task automatic wait_cnt_wr();
      int waited;
      waited = 0;
      @(negedge inp);
      while (!cnt_wr) begin
         waited++;
         if (waited > TIMEOUT) begin
            fail_run("Timeout: the counter write-back never came");
         end
         next_cycle();
         @(negedge inp);
      end
      next_cycle();
   endtask

   // ===================================================================
   // Directed tests
   // ===================================================================
   task automatic bypass_packet(input int p);
      make_payload(3, 48, p, 1'b1);
      exp_q = sent_q;
      send_packet();
      receive_packet();
   endtask

   task automatic verified_packet(input int p, input int n, input int len);
      logic [7:0] mask;
      beat_s      b;
      make_payload(n, len, p, 1'b0);
      exp_q.delete();
      add_expected_header(p, len);
      mask = init_recs[p].key[7:0] ^ exp_cnt[p][7:0];
      foreach (sent_q[i]) begin
         b      = sent_q[i];
         b.data = b.data ^ {16{mask}};
         exp_q.push_back(b);
      end
      cipher_pass = 1'b1;
      send_packet();
      receive_packet();
      check("peer_idx", 128'(peer_idx), 128'(p));
      check("cipher_key[127:0]", cipher_key[127:0], init_recs[p].key[127:0]);
      check("cipher_key[255:128]", cipher_key[255:128], init_recs[p].key[255:128]);
      check("cipher_nonce", 128'(cipher_nonce), 128'(exp_cnt[p]));
      check("peer_table.send_cnt", 128'(peer_table[p].send_cnt),
            128'(exp_cnt[p] + counter_t'(1)));
      exp_cnt[p] = exp_cnt[p] + counter_t'(1);
   endtask

   // Inner length 33 pads to 48, so IP 108 and UDP 88
   task automatic length_fields();
      verified_packet(2, 3, 33);
      check("ip_len", 128'({got_q[1].data[7:0], got_q[1].data[15:8]}), 128'(108));
      check("udp_len", 128'({got_q[2].data[55:48], got_q[2].data[63:56]}), 128'(88));
   endtask

   task automatic dropped_packet(input int p);
      make_payload(2, 24, p, 1'b0);
      cipher_pass = 1'b0;
      out_ready   = 1'b1;
      send_packet();
      wait_cnt_wr();
      check("peer_table.send_cnt", 128'(peer_table[p].send_cnt),
            128'(exp_cnt[p] + counter_t'(1)));
      exp_cnt[p] = exp_cnt[p] + counter_t'(1);
      for (int i = 0; i < 12; i++) begin
         @(negedge inp);
         check("out_valid", 128'(out_valid), 128'(0));
      end
      next_cycle();
      out_ready = 1'b0;
      bypass_packet(p);
   endtask

   task automatic counter_advance(input int p);
      counter_t c0;
      c0 = exp_cnt[p];
      verified_packet(p, 2, 20);
      verified_packet(p, 2, 20);
      check("header send_cnt", 128'(got_q[3].data[79:16]), 128'(c0 + counter_t'(1)));
   endtask

   task automatic reset_outputs();
      @(negedge inp);
      check("in_ready", 128'(in_ready), 128'(0));
      check("out_valid", 128'(out_valid), 128'(0));
      check("cnt_wr", 128'(cnt_wr), 128'(0));
      check("cipher_in_valid", 128'(cipher_in_valid), 128'(0));
      check("cipher_out_ready", 128'(cipher_out_ready), 128'(0));
      check("hdr_valid", 128'(uut.hdr_valid), 128'(0));
      next_cycle();
   endtask

   initial begin : main
      void'($urandom(82513));
      rst         = 1'b1;
      in_beat     = '0;
      in_valid    = 1'b0;
      out_ready   = 1'b0;
      cipher_pass = 1'b0;
      stall_out   = 1'b0;
      for (int p = 0; p < PEERS; p++) begin
         init_recs[p].local_mac   = {40'h02_00_5e_00_01, 8'(p)};
         init_recs[p].local_ip    = 32'hc0a8_0001;
         init_recs[p].local_port  = 16'd51820;
         init_recs[p].remote_mac  = {40'h02_00_5e_00_02, 8'(p)};
         init_recs[p].remote_ip   = {24'h0a_0000, 8'(p + 1)};
         init_recs[p].remote_port = 16'd51820 + 16'(p);
         init_recs[p].remote_id   = $urandom();
         init_recs[p].key         = {$urandom(), $urandom(), $urandom(), $urandom(),
                                     $urandom(), $urandom(), $urandom(), $urandom()};
         init_recs[p].send_cnt    = {32'h0000_0001, $urandom()};
         exp_cnt[p]               = init_recs[p].send_cnt;
      end
      repeat (3) @(posedge inp);
      #2;
      rst = 1'b0;

      reset_outputs();
      bypass_packet(2);
      verified_packet(1, 2, 32);
      length_fields();
      dropped_packet(0);
      counter_advance(1);
      stall_out = 1'b1;
      verified_packet(3, 4, 61);
      stall_out = 1'b0;

      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire
